/* design/pcx_pkg.sv */
// PCX request crossbar definitions
`default_nettype none

package pcx_pkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   // Two cores share the crossbar
   localparam int pcx_num_cores = 2;

   // Four cache banks at indices 0 to 3, the I/O port at index 4
   localparam int pcx_num_dest = 5;

   // Packets a core may have outstanding toward one destination
   // The arbiter sizes its per-core source queues from this same number
   localparam int pcx_src_credits = 2;

   //////////////////////////////
   // Packet types
   //////////////////////////////

   // Destination index, wide enough for all five targets
   typedef logic [2:0] pcx_dest_t;

   // Request kinds carried with every packet
   typedef enum logic [1:0] {
      pcx_load        = 2'd0,
      pcx_store       = 2'd1,
      pcx_atom_first  = 2'd2,
      pcx_atom_second = 2'd3
   } pcx_kind_e;

   // One packet as the core hands it over, 53 bits in all
   typedef struct packed {
      pcx_dest_t   dest;
      pcx_kind_e   kind;
      logic [15:0] addr;
      logic [31:0] data;
   } pcx_pkt_t;

   // The bank also needs to know which core sent the packet
   typedef struct packed {
      logic     core_id;
      pcx_pkt_t pkt;
   } pcx_out_pkt_t;

   //////////////////////////////
   // Request and grant bundles
   //////////////////////////////

   // One core's request lines for one cycle
   // The dest vector is one-hot and atom marks the first half of a pair
   typedef struct packed {
      logic [pcx_num_dest-1:0] dest;
      logic                    atom;
      pcx_pkt_t                pkt;
   } pcx_req_t;

   // One grant bit per destination, as seen by a single core
   typedef logic [pcx_num_dest-1:0] pcx_gnt_t;

endpackage

`default_nettype wire

/* design/pcx_core_port.sv */
// Core-side request source
`default_nettype none

module pcx_core_port (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              core_valid,
   input  pcx_pkg::pcx_pkt_t core_pkt,
   output logic              core_ready,
   output pcx_pkg::pcx_req_t req_l,
   input  pcx_pkg::pcx_gnt_t gnt_l
);
   import pcx_pkg::*;

   // Credits left per destination, 0 to pcx_src_credits
   logic [1:0]              credit_q [pcx_num_dest];

   // Set between an accepted atomic first and its second half
   logic                    atom_pend_q;
   pcx_dest_t               atom_dest_q;

   // Registered request bundle, kept active high internally
   logic [pcx_num_dest-1:0] req_dest_q;
   logic                    req_atom_q;
   pcx_pkt_t                req_pkt_q;

   pcx_dest_t               issue_dest;
   logic [1:0]              cur_credit;
   logic [1:0]              need;
   logic                    dest_ok;
   logic                    fire;
   logic                    start_atom;
   logic [pcx_num_dest-1:0] issue_vec;
   pcx_gnt_t                gnt;

   // Grants arrive active low from the repeater
   assign gnt = ~gnt_l;

   //////////////////////////////
   // Ready and issue decode
   //////////////////////////////

   always_comb begin
      // The second half of a pair always goes where the first went
      issue_dest = atom_pend_q ? atom_dest_q : core_pkt.dest;
      cur_credit = 2'd0;
      dest_ok    = 1'b0;
      for (int d = 0; d < pcx_num_dest; d++) begin
         if (issue_dest == pcx_dest_t'(d)) begin
            cur_credit = credit_q[d];
            dest_ok    = 1'b1;
         end
      end
      // A pair needs room for both halves before the first one goes
      need = (core_pkt.kind == pcx_atom_first) ? 2'd2 : 2'd1;
      // Credit for the second half was reserved when the first was taken
      if (atom_pend_q) begin
         core_ready = 1'b1;
      end else begin
         core_ready = dest_ok && (cur_credit >= need);
      end
      fire       = core_valid && core_ready;
      start_atom = fire && !atom_pend_q && (core_pkt.kind == pcx_atom_first);
      issue_vec  = '0;
      for (int d = 0; d < pcx_num_dest; d++) begin
         issue_vec[d] = fire && (issue_dest == pcx_dest_t'(d));
      end
   end

   //////////////////////////////
   // Credit counters
   //////////////////////////////

   // One credit leaves on acceptance and one comes back per grant bit
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int d = 0; d < pcx_num_dest; d++) begin
            credit_q[d] <= 2'(pcx_src_credits);
         end
      end else begin
         for (int d = 0; d < pcx_num_dest; d++) begin
            credit_q[d] <= credit_q[d] - 2'(issue_vec[d]) + 2'(gnt[d]);
         end
      end
   end

   // Atomic pair tracking and the request pulse itself
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         atom_pend_q <= 1'b0;
         atom_dest_q <= '0;
         req_dest_q  <= '0;
         req_atom_q  <= 1'b0;
      end else begin
         if (fire) begin
            atom_pend_q <= start_atom;
         end
         if (start_atom) begin
            atom_dest_q <= core_pkt.dest;
         end
         // The pulse lasts one cycle since issue_vec is clear when idle
         req_dest_q <= issue_vec;
         req_atom_q <= start_atom;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         req_pkt_q <= core_pkt;
      end
   end

   // Request lines leave the port active low
   always_comb begin
      req_l.dest = ~req_dest_q;
      req_l.atom = ~req_atom_q;
      req_l.pkt  = ~req_pkt_q;
   end

endmodule

`default_nettype wire

/* design/pcx_repeater.sv */
// Registered request and grant repeater
`default_nettype none

module pcx_repeater (
   input  logic              clk,
   input  logic              rst_n,
   input  pcx_pkg::pcx_req_t req_in_l  [pcx_pkg::pcx_num_cores],
   output pcx_pkg::pcx_req_t req_out   [pcx_pkg::pcx_num_cores],
   input  pcx_pkg::pcx_gnt_t gnt_in    [pcx_pkg::pcx_num_cores],
   output pcx_pkg::pcx_gnt_t gnt_out_l [pcx_pkg::pcx_num_cores]
);
   import pcx_pkg::*;

   // Outward request lines, already converted to active high
   logic [pcx_num_dest-1:0] dest_q [pcx_num_cores];
   logic                    atom_q [pcx_num_cores];
   pcx_pkt_t                pkt_q  [pcx_num_cores];

   // Returning grants, stored active high
   pcx_gnt_t                gnt_q  [pcx_num_cores];

   // Control lines come out of reset idle in both directions
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            dest_q[c] <= '0;
            atom_q[c] <= 1'b0;
            gnt_q[c]  <= '0;
         end
      end else begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            dest_q[c] <= ~req_in_l[c].dest;
            atom_q[c] <= ~req_in_l[c].atom;
            gnt_q[c]  <= gnt_in[c];
         end
      end
   end

   // Packet payload only matters when a dest bit is set
   always_ff @(posedge clk) begin
      for (int c = 0; c < pcx_num_cores; c++) begin
         pkt_q[c] <= ~req_in_l[c].pkt;
      end
   end

   always_comb begin
      for (int c = 0; c < pcx_num_cores; c++) begin
         req_out[c].dest = dest_q[c];
         req_out[c].atom = atom_q[c];
         req_out[c].pkt  = pkt_q[c];
         // Back toward the cores the grants run active low
         gnt_out_l[c]    = ~gnt_q[c];
      end
   end

endmodule

`default_nettype wire

/* design/pcx_dest_arbiter.sv */
// Destination arbiter with source queues
`default_nettype none

module pcx_dest_arbiter (
   input  logic                                clk,
   input  logic                                rst_n,
   input  pcx_pkg::pcx_dest_t                  dest_id,
   input  pcx_pkg::pcx_req_t                   req [pcx_pkg::pcx_num_cores],
   input  logic [3:0]                          slots_free,
   output logic [pcx_pkg::pcx_num_cores-1:0]   gnt,
   output logic                                push,
   output pcx_pkg::pcx_out_pkt_t               push_pkt
);
   import pcx_pkg::*;

   localparam int src_ptr_w = $clog2(pcx_src_credits);

   // Per-core source queues, one entry per outstanding credit
   pcx_pkt_t               src_pkt  [pcx_num_cores][pcx_src_credits];
   logic                   src_atom [pcx_num_cores][pcx_src_credits];
   logic [src_ptr_w-1:0]   wr_ptr_q [pcx_num_cores];
   logic [src_ptr_w-1:0]   rd_ptr_q [pcx_num_cores];
   logic [src_ptr_w:0]     count_q  [pcx_num_cores];

   // Round-robin priority and the lock held across an atomic pair
   logic                   prio_q;
   logic                   lock_q;
   logic                   lock_core_q;

   logic [pcx_num_cores-1:0] arrive;
   logic [pcx_num_cores-1:0] head_atom;
   logic [pcx_num_cores-1:0] elig;
   logic                     sel;

   function automatic logic [src_ptr_w-1:0] ptr_inc(input logic [src_ptr_w-1:0] ptr);
      return (ptr == src_ptr_w'(pcx_src_credits - 1)) ? '0 : ptr + 1'b1;
   endfunction

   //////////////////////////////
   // Head selection
   //////////////////////////////

   always_comb begin
      for (int c = 0; c < pcx_num_cores; c++) begin
         arrive[c]    = req[c].dest[dest_id];
         head_atom[c] = src_atom[c][rd_ptr_q[c]];
         // An atomic first needs both queue slots before it may start
         elig[c]      = (count_q[c] != '0) &&
                        (slots_free >= (head_atom[c] ? 4'd2 : 4'd1));
      end
      if (lock_q) begin
         // Hold the destination until the pair's second half has moved
         sel  = lock_core_q;
         push = elig[lock_core_q];
      end else if (elig[prio_q]) begin
         sel  = prio_q;
         push = 1'b1;
      end else begin
         sel  = !prio_q;
         push = elig[!prio_q];
      end
      for (int c = 0; c < pcx_num_cores; c++) begin
         gnt[c] = push && (sel == 1'(c));
      end
      push_pkt.core_id = sel;
      push_pkt.pkt     = src_pkt[sel][rd_ptr_q[sel]];
   end

   //////////////////////////////
   // State update
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            wr_ptr_q[c] <= '0;
            rd_ptr_q[c] <= '0;
            count_q[c]  <= '0;
         end
         prio_q      <= 1'b0;
         lock_q      <= 1'b0;
         lock_core_q <= 1'b0;
      end else begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            if (arrive[c]) begin
               wr_ptr_q[c] <= ptr_inc(wr_ptr_q[c]);
            end
            if (gnt[c]) begin
               rd_ptr_q[c] <= ptr_inc(rd_ptr_q[c]);
            end
            count_q[c] <= count_q[c] + (src_ptr_w + 1)'(arrive[c]) -
                          (src_ptr_w + 1)'(gnt[c]);
         end
         if (push) begin
            // The other core goes first next time
            prio_q <= !sel;
            if (lock_q) begin
               lock_q <= 1'b0;
            end else if (head_atom[sel]) begin
               lock_q      <= 1'b1;
               lock_core_q <= sel;
            end
         end
      end
   end

   // Entries are written on the edge where the request arrives
   always_ff @(posedge clk) begin
      for (int c = 0; c < pcx_num_cores; c++) begin
         if (arrive[c]) begin
            src_pkt[c][wr_ptr_q[c]]  <= req[c].pkt;
            src_atom[c][wr_ptr_q[c]] <= req[c].atom;
         end
      end
   end

endmodule

`default_nettype wire

/* design/pcx_dest_queue.sv */
// Destination FIFO toward one bank
`default_nettype none

module pcx_dest_queue #(
   parameter int queue_depth  = 4,
   parameter int bank_credits = 2
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  pcx_pkg::pcx_out_pkt_t push_pkt,
   output logic [3:0]            slots_free,
   output logic                  bank_valid,
   output pcx_pkg::pcx_out_pkt_t bank_pkt,
   input  logic                  bank_credit
);
   import pcx_pkg::*;

   localparam int ptr_w  = $clog2(queue_depth);
   localparam int cred_w = $clog2(bank_credits + 1);

   pcx_out_pkt_t      mem [queue_depth];
   logic [ptr_w-1:0]  wr_ptr_q;
   logic [ptr_w-1:0]  rd_ptr_q;
   logic [3:0]        count_q;
   // Credits the bank has granted but not yet used
   logic [cred_w-1:0] credit_q;
   logic              pop;

   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Send the head whenever there is one and the bank has room
   assign pop = (count_q != 4'd0) && (credit_q != '0);

   // A slot freed by this cycle's pop shows up one cycle later
   assign slots_free = 4'(queue_depth) - count_q;

   //////////////////////////////
   // Pointers and counters
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= 4'd0;
         credit_q   <= cred_w'(bank_credits);
         bank_valid <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         count_q    <= count_q + 4'(push) - 4'(pop);
         // Each send spends a credit and each bank pulse returns one
         credit_q   <= credit_q - cred_w'(pop) + cred_w'(bank_credit);
         bank_valid <= pop;
      end
   end

   //////////////////////////////
   // Storage and bank output
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= push_pkt;
      end
      if (pop) begin
         bank_pkt <= mem[rd_ptr_q];
      end
   end

endmodule

`default_nettype wire

/* design/pcx_top.sv */
// PCX request crossbar top level
`default_nettype none

module pcx_top #(
   parameter int queue_depth  = 4,
   parameter int bank_credits = 2
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  core_valid  [pcx_pkg::pcx_num_cores],
   input  pcx_pkg::pcx_pkt_t     core_pkt    [pcx_pkg::pcx_num_cores],
   output logic                  core_ready  [pcx_pkg::pcx_num_cores],
   output logic                  bank_valid  [pcx_pkg::pcx_num_dest],
   output pcx_pkg::pcx_out_pkt_t bank_pkt    [pcx_pkg::pcx_num_dest],
   input  logic                  bank_credit [pcx_pkg::pcx_num_dest]
);
   import pcx_pkg::*;

   // Core side of the repeater, active low
   pcx_req_t                 core_req_l [pcx_num_cores];
   pcx_gnt_t                 core_gnt_l [pcx_num_cores];

   // Crossbar side of the repeater, active high
   pcx_req_t                 arb_req    [pcx_num_cores];
   wire pcx_gnt_t            rep_gnt    [pcx_num_cores];

   // Per-destination arbiter outputs and queue feedback
   logic [pcx_num_cores-1:0] arb_gnt    [pcx_num_dest];
   logic                     push       [pcx_num_dest];
   pcx_out_pkt_t             push_pkt   [pcx_num_dest];
   logic [3:0]               slots_free [pcx_num_dest];

   //////////////////////////////
   // Core ports and repeater
   //////////////////////////////

   for (genvar c = 0; c < pcx_num_cores; c++) begin : g_core
      pcx_core_port i_core_port (
         .clk        (clk),
         .rst_n      (rst_n),
         .core_valid (core_valid[c]),
         .core_pkt   (core_pkt[c]),
         .core_ready (core_ready[c]),
         .req_l      (core_req_l[c]),
         .gnt_l      (core_gnt_l[c])
      );

      // Each core collects its grant bit from every destination
      for (genvar d = 0; d < pcx_num_dest; d++) begin : g_gnt
         assign rep_gnt[c][d] = arb_gnt[d][c];
      end
   end

   pcx_repeater i_repeater (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_in_l  (core_req_l),
      .req_out   (arb_req),
      .gnt_in    (rep_gnt),
      .gnt_out_l (core_gnt_l)
   );

   //////////////////////////////
   // Destination slices
   //////////////////////////////

   for (genvar d = 0; d < pcx_num_dest; d++) begin : g_dest
      pcx_dest_arbiter i_arbiter (
         .clk        (clk),
         .rst_n      (rst_n),
         .dest_id    (pcx_dest_t'(d)),
         .req        (arb_req),
         .slots_free (slots_free[d]),
         .gnt        (arb_gnt[d]),
         .push       (push[d]),
         .push_pkt   (push_pkt[d])
      );

      pcx_dest_queue #(
         .queue_depth  (queue_depth),
         .bank_credits (bank_credits)
      ) i_queue (
         .clk         (clk),
         .rst_n       (rst_n),
         .push        (push[d]),
         .push_pkt    (push_pkt[d]),
         .slots_free  (slots_free[d]),
         .bank_valid  (bank_valid[d]),
         .bank_pkt    (bank_pkt[d]),
         .bank_credit (bank_credit[d])
      );
   end

endmodule

`default_nettype wire

/* tb/pcx_tb.sv */
// PCX crossbar testbench
`default_nettype none

module pcx_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import pcx_pkg::*;

   localparam int queue_depth  = 4;
   localparam int bank_credits = 2;
   localparam int clk_period   = 4;

   // The watchdog is sized from the packets that each test offers
   localparam int total_pkts      = 10 + 12 + 24 + 40 + 60 + 400;
   localparam int watchdog_cycles = total_pkts * 20;

   logic         clk = 1'b0;
   logic         rst_n;
   logic         core_valid  [pcx_num_cores];
   pcx_pkt_t     core_pkt    [pcx_num_cores];
   logic         core_ready  [pcx_num_cores];
   logic         bank_valid  [pcx_num_dest];
   pcx_out_pkt_t bank_pkt    [pcx_num_dest];
   logic         bank_credit [pcx_num_dest];

   // Packets still to be offered by each core
   pcx_pkt_t     stim_q [pcx_num_cores][$];
   // Reference model of what each bank must still see from each core in order
   pcx_out_pkt_t exp_q  [pcx_num_cores][pcx_num_dest][$];
   int           acc_cnt [pcx_num_cores];

   // Bank model controls
   logic         bank_hold;
   int           bank_delay [pcx_num_dest];

   // Atomic adjacency and fairness state per bank
   logic         pair_open [pcx_num_dest];
   logic         pair_core [pcx_num_dest];
   logic         fair_on;
   logic         run_core  [pcx_num_dest];
   int           run_len   [pcx_num_dest];

   logic [31:0]  rng_state;

   pcx_top #(
      .queue_depth  (queue_depth),
      .bank_credits (bank_credits)
   ) i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .core_valid  (core_valid),
      .core_pkt    (core_pkt),
      .core_ready  (core_ready),
      .bank_valid  (bank_valid),
      .bank_pkt    (bank_pkt),
      .bank_credit (bank_credit)
   );

   always #(clk_period / 2) clk = ~clk;

   //////////////////////////////
   // Helpers and checks
   //////////////////////////////

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Address and data are random and the test picks the rest
   function automatic pcx_pkt_t make_pkt(input int dest, input pcx_kind_e kind);
      pcx_pkt_t    p;
      logic [31:0] r;
      r      = xorshift32();
      p.dest = pcx_dest_t'(dest);
      p.kind = kind;
      p.addr = r[15:0];
      p.data = xorshift32();
      return p;
   endfunction

   task automatic queue_single(input int c, input int dest, input pcx_kind_e kind);
      stim_q[c].push_back(make_pkt(dest, kind));
   endtask

   // Both halves go in together so the driver offers them back to back
   task automatic queue_pair(input int c, input int dest);
      stim_q[c].push_back(make_pkt(dest, pcx_atom_first));
      stim_q[c].push_back(make_pkt(dest, pcx_atom_second));
   endtask

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR at %0.1f ns: %s expected %b, actual %b", $realtime, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_pkt(input string name, input pcx_out_pkt_t exp,
                            input pcx_out_pkt_t act);
      if (act !== exp) begin
         $display("ERROR at %0.1f ns: %s expected %h, actual %h", $realtime, name, exp, act);
         abort_run();
      end
   endtask

   // Everything a bank receives is checked here
   task automatic bank_receive(input int d, input pcx_out_pkt_t act);
      pcx_out_pkt_t exp;
      if (exp_q[act.core_id][d].size() == 0) begin
         $display("Bank %0d got a packet from core %0d that was never sent", d, act.core_id);
         abort_run();
      end
      exp = exp_q[act.core_id][d].pop_front();
      check_pkt($sformatf("bank_pkt[%0d]", d), exp, act);
      // The second half must follow its first with nothing in between
      if (pair_open[d] && (act.core_id != pair_core[d] || act.pkt.kind != pcx_atom_second)) begin
         $display("Atomic pair at bank %0d was split by another packet", d);
         abort_run();
      end
      pair_open[d] = (act.pkt.kind == pcx_atom_first);
      pair_core[d] = act.core_id;
      // Runs of plain requests from one core stay short while both compete
      if (fair_on && !act.pkt.kind[1]) begin
         if (run_len[d] > 0 && run_core[d] == act.core_id) begin
            run_len[d]++;
         end else begin
            run_core[d] = act.core_id;
            run_len[d]  = 1;
         end
         if (run_len[d] > 2) begin
            $display("Core %0d got more than two packets in a row at bank %0d", act.core_id, d);
            abort_run();
         end
      end else begin
         run_len[d] = 0;
      end
   endtask

   //////////////////////////////
   // Core drivers and bank model
   //////////////////////////////

   for (genvar c = 0; c < pcx_num_cores; c++) begin : g_drv
      logic take;
      initial begin
         core_valid[c] = 1'b0;
         core_pkt[c]   = '0;
         forever begin
            // Inputs are steady here, so this is the handshake of the next edge
            @(negedge clk);
            take = core_valid[c] && core_ready[c];
            @(posedge clk);
            #0.5;
            if (take) begin
               exp_q[c][stim_q[c][0].dest].push_back(
                  pcx_out_pkt_t'{core_id: 1'(c), pkt: stim_q[c][0]});
               void'(stim_q[c].pop_front());
               acc_cnt[c]++;
            end
            core_valid[c] = (stim_q[c].size() != 0);
            if (stim_q[c].size() != 0) begin
               core_pkt[c] = stim_q[c][0];
            end
         end
      end
   end

   for (genvar d = 0; d < pcx_num_dest; d++) begin : g_bank
      int owed;
      int wait_cnt;
      initial begin
         owed           = 0;
         wait_cnt       = 0;
         bank_credit[d] = 1'b0;
         forever begin
            @(negedge clk);
            if (bank_valid[d]) begin
               bank_receive(d, bank_pkt[d]);
               owed++;
               if (owed > bank_credits) begin
                  $display("Bank %0d was sent more packets than it has credits for", d);
                  abort_run();
               end
            end
            @(posedge clk);
            #0.5;
            bank_credit[d] = 1'b0;
            // One credit goes back per packet, after the bank's delay
            if (!bank_hold && owed > 0 && wait_cnt >= bank_delay[d]) begin
               bank_credit[d] = 1'b1;
               owed--;
               wait_cnt = 0;
            end else if (owed > 0) begin
               wait_cnt++;
            end
         end
      end
   end

   // Returns once nothing waits to be sent and every expected packet has arrived
   task automatic wait_drain();
      logic busy;
      busy = 1'b1;
      while (busy) begin
         @(negedge clk);
         busy = 1'b0;
         for (int c = 0; c < pcx_num_cores; c++) begin
            if (stim_q[c].size() != 0 || core_valid[c]) begin
               busy = 1'b1;
            end
            for (int d = 0; d < pcx_num_dest; d++) begin
               if (exp_q[c][d].size() != 0) begin
                  busy = 1'b1;
               end
            end
         end
      end
      // Lets bank and core credits flow home before the next test
      repeat (20) @(negedge clk);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_reset_and_loads();
      for (int c = 0; c < pcx_num_cores; c++) begin
         check_bit($sformatf("core_ready[%0d]", c), 1'b1, core_ready[c]);
      end
      for (int d = 0; d < pcx_num_dest; d++) begin
         check_bit($sformatf("bank_valid[%0d]", d), 1'b0, bank_valid[d]);
      end
      for (int c = 0; c < pcx_num_cores; c++) begin
         for (int d = 0; d < pcx_num_dest; d++) begin
            queue_single(c, d, pcx_load);
         end
      end
      wait_drain();
   endtask

   task automatic test_credit_limit();
      int start_cnt;
      int stall;
      int accepted;
      bank_hold = 1'b1;
      start_cnt = acc_cnt[0];
      for (int i = 0; i < 12; i++) begin
         queue_single(0, 1, pcx_load);
      end
      // Ready stays low for good only once every buffer on the path is full
      stall = 0;
      while (stall < 16) begin
         @(negedge clk);
         stall = (core_ready[0] === 1'b0) ? stall + 1 : 0;
      end
      accepted = acc_cnt[0] - start_cnt;
      // FIFO slots, the bank's own credits and the core's source entries
      if (accepted > queue_depth + bank_credits + pcx_src_credits) begin
         $display("Core 0 got %0d packets accepted, more than the path can hold", accepted);
         abort_run();
      end
      bank_hold = 1'b0;
      wait_drain();
      // Every credit toward bank 1 has come home once the path is empty
      check_bit("core_ready[0]", 1'b1, core_ready[0]);
   endtask

   task automatic test_atomic_pairs();
      for (int i = 0; i < 4; i++) begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            queue_pair(c, 2);
            queue_single(c, 2, pcx_load);
         end
      end
      wait_drain();
   endtask

   task automatic test_fairness();
      fair_on = 1'b1;
      for (int i = 0; i < 20; i++) begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            queue_single(c, 3, pcx_load);
         end
      end
      wait_drain();
      fair_on = 1'b0;
   endtask

   task automatic test_bank_backpressure();
      logic [31:0] r;
      for (int d = 0; d < pcx_num_dest; d++) begin
         bank_delay[d] = 2 * d;
      end
      for (int i = 0; i < 30; i++) begin
         for (int c = 0; c < pcx_num_cores; c++) begin
            r = xorshift32();
            queue_single(c, int'(r % 5), r[8] ? pcx_store : pcx_load);
         end
      end
      wait_drain();
   endtask

   task automatic test_random_traffic();
      logic [31:0] r;
      int          n;
      for (int d = 0; d < pcx_num_dest; d++) begin
         r = xorshift32();
         bank_delay[d] = int'(r % 6);
      end
      for (int c = 0; c < pcx_num_cores; c++) begin
         n = 0;
         while (n < 200) begin
            r = xorshift32();
            // About one slot in four starts an atomic pair
            if (r[9:8] == 2'b00 && n < 199) begin
               queue_pair(c, int'(r % 5));
               n = n + 2;
            end else begin
               queue_single(c, int'(r % 5), r[10] ? pcx_store : pcx_load);
               n = n + 1;
            end
         end
      end
      wait_drain();
   endtask

   //////////////////////////////
   // Sequence and watchdog
   //////////////////////////////

   initial begin
      rst_n     = 1'b0;
      bank_hold = 1'b0;
      fair_on   = 1'b0;
      rng_state = 32'h513f_7119;
      for (int c = 0; c < pcx_num_cores; c++) begin
         acc_cnt[c] = 0;
      end
      for (int d = 0; d < pcx_num_dest; d++) begin
         bank_delay[d] = 0;
         pair_open[d]  = 1'b0;
         pair_core[d]  = 1'b0;
         run_core[d]   = 1'b0;
         run_len[d]    = 0;
      end
      repeat (4) @(posedge clk);
      #0.5;
      rst_n = 1'b1;
      @(negedge clk);
      test_reset_and_loads();
      test_credit_limit();
      test_atomic_pairs();
      test_fairness();
      test_bank_backpressure();
      test_random_traffic();
      $display("All tests passed!");
      $finish;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("Watchdog expired before the tests finished, traffic seems stuck");
      abort_run();
   end

endmodule

`default_nettype wire

/* project.f */
design/pcx_pkg.sv
design/pcx_core_port.sv
design/pcx_repeater.sv
design/pcx_dest_arbiter.sv
design/pcx_dest_queue.sv
design/pcx_top.sv
tb/pcx_tb.sv
